// File: obj_engine.f
+incdir+rtl
rtl/obj_pkg.sv
rtl/obj_loader.sv
rtl/obj_shifter.sv
rtl/obj_mixer.sv
rtl/obj_engine.sv
verification/obj_engine_asserts.sv
verification/obj_engine_tb.sv

// File: verification/obj_engine_tb.sv
/* line scenarios for the sprite unit, slot count taken from obj_cfg.svh
   h parks at 255 outside the sweep, so no drawn sprite may sit at x = 255
   ROM is a scramble of the address with one clock of latency */

`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_engine_tb;
    import obj_pkg::*;

    localparam int        NUM_LINES = 7;
    localparam logic [7:0] IDLE_H   = 8'hff;  // h while loading

    typedef struct packed {
        obj_attr_t [4:0] spr;       // attributes in strobe order
        logic            vb;
        logic [2:0]      cnt;       // attributes strobed this line
        logic [2:0]      exp_rd;    // rom reads the line must produce
    } line_t;

    logic                   clk;
    logic                   arst_n;
    logic                   line_start;
    logic                   attr_we;
    obj_attr_t              attr;
    logic [7:0]             h;
    logic                   vb;
    logic [`OBJ_ADDR_W-1:0] rom_addr;
    logic                   rom_rd;
    logic [31:0]            rom_data;
    obj_pix_t               pix;

    line_t  tab [NUM_LINES];
    line_t  cur;            // line being swept
    int     rd_cnt;         // reads seen in the current line
    int     errors;
    int     seed;

    obj_engine dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .line_start (line_start),
        .attr_we    (attr_we),
        .attr       (attr),
        .h          (h),
        .vb         (vb),
        .rom_addr   (rom_addr),
        .rom_rd     (rom_rd),
        .rom_data   (rom_data),
        .pix        (pix)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns
    end

    // plane 1 in the upper half, plane 0 in the lower
    function automatic logic [31:0] rom_word(input logic [`OBJ_ADDR_W-1:0] addr);
        logic [15:0] a;
        a = 16'(addr);
        return {a ^ 16'h5a3c, a * 16'd3 + 16'd1};
    endfunction

    always @(posedge clk) rom_data <= rom_word(rom_addr);  // synchronous rom

    // front-most opaque sprite at column col, slot order = strobe order
    function automatic obj_pix_t expected_pix(input line_t ln, input int col);
        obj_pix_t    p;
        obj_attr_t   s;
        logic [31:0] w;
        logic [1:0]  v;
        int          n;
        int          idx;
        int          b;
        bit          found;
        p = '0;
        found = 1'b0;
        n = (ln.cnt > `OBJ_SLOTS) ? `OBJ_SLOTS : ln.cnt;  // extras dropped
        for (int k = 0; k < n; k++) begin
            s = ln.spr[k];
            idx = col - int'(s.x);
            if (!found && idx >= 0 && idx < 16) begin
                w = rom_word({s.code, s.row});
                b = s.hflip ? 15 - idx : idx;   // mirrored reads from bit 15
                v = {w[16 + b], w[b]};
                if (v != 2'b00) begin
                    p.colour = s.colour;
                    p.value  = v;
                    found    = 1'b1;
                end
            end
        end
        if (ln.vb) p.value = 2'b00;    // colour survives blanking
        return p;
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic set_line(input int idx, input logic vb_f, input logic [2:0] cnt,
                            input logic [2:0] exp_rd);
        tab[idx].vb     = vb_f;
        tab[idx].cnt    = cnt;
        tab[idx].exp_rd = exp_rd;
    endtask

    task automatic set_sprite(input int idx, input int slot, input logic [7:0] x,
                              input logic [`OBJ_CODE_W-1:0] code,
                              input logic [`OBJ_ROW_W-1:0] row,
                              input logic [2:0] colour, input logic hflip);
        tab[idx].spr[slot].x      = x;
        tab[idx].spr[slot].code   = code;
        tab[idx].spr[slot].row    = row;
        tab[idx].spr[slot].colour = colour;
        tab[idx].spr[slot].hflip  = hflip;
    endtask

    task automatic build_table();
        for (int i = 0; i < NUM_LINES; i++) begin
            for (int j = 0; j < 5; j++) tab[i].spr[j] = 25'($urandom); // unused slots
        end
        set_line(0, 0, 1, 1);       // plain sprite
        set_sprite(0, 0, 40, 9'h123, 5, 3, 0);
        set_line(1, 0, 1, 1);       // mirrored
        set_sprite(1, 0, 100, 9'h0a7, 9, 6, 1);
        set_line(2, 0, 3, 3);       // slots 0 and 2 overlap at 66..75
        set_sprite(2, 0, 60, 9'h011, 2, 1, 0);
        set_sprite(2, 1, 150, 9'h1f0, 14, 2, 1);
        set_sprite(2, 2, 66, 9'h0c3, 7, 5, 0);
        set_line(3, 0, 5, 4);       // fifth one must vanish
        set_sprite(3, 0, 10, 9'h040, 1, 1, 0);
        set_sprite(3, 1, 30, 9'h081, 3, 2, 1);
        set_sprite(3, 2, 50, 9'h102, 6, 4, 0);
        set_sprite(3, 3, 248, 9'h1c3, 8, 7, 1);    // still shifting at line end
        set_sprite(3, 4, 90, 9'h0ff, 15, 3, 0);
        set_line(4, 0, 0, 0);       // empty, leftover run cut by line_start
        set_line(5, 1, 2, 2);       // blanked
        set_sprite(5, 0, 20, 9'h055, 4, 2, 0);
        set_sprite(5, 1, 28, 9'h1aa, 11, 5, 1);
        set_line(6, 0, 1, 1);       // runs off the right edge
        set_sprite(6, 0, 248, 9'h17e, 12, 7, 0);
    endtask

    // step to the next falling edge and look at the rom port
    task automatic next_cycle();
        @(negedge clk);
        if (rom_rd === 1'b1) begin
            if (rd_cnt < cur.exp_rd)
                check("rom_addr", rom_addr, {cur.spr[rd_cnt].code, cur.spr[rd_cnt].row});
            else
                check("rom_rd", 1, 0);  // read past the slot count
            rd_cnt++;
        end
    endtask

    task automatic run_line(input line_t ln);
        obj_pix_t exp_p;
        cur    = ln;
        rd_cnt = 0;
        next_cycle();
        line_start = 1'b1;
        vb         = ln.vb;
        next_cycle();
        line_start = 1'b0;
        for (int j = 0; j < ln.cnt; j++) begin
            attr_we = 1'b1;
            attr    = ln.spr[j];
            next_cycle();
            attr_we = 1'b0;
            next_cycle();           // strobes 2 clocks apart
        end
        repeat (3) next_cycle();    // last row lands in its slot
        for (int col = 0; col <= 256; col++) begin
            if (col > 0) begin
                exp_p = expected_pix(ln, col - 1);  // pix lags h by one clock
                check($sformatf("pix at h=%0d", col - 1), pix, exp_p);
            end
            h = (col < 256) ? 8'(col) : IDLE_H;
            next_cycle();
        end
        check("rom_rd count", rd_cnt, ln.exp_rd);
    endtask

    initial begin
        repeat (16 + NUM_LINES * 300) @(posedge clk);
        $display("watchdog expired, the run hung before all lines were swept");
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed       = $urandom(32'h6f53);
        errors     = 0;
        arst_n     = 1'b0;
        line_start = 1'b0;
        attr_we    = 1'b0;
        attr       = '0;
        h          = IDLE_H;
        vb         = 1'b0;
        rom_data   = '0;
        rd_cnt     = 0;
        build_table();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check("pix", pix, 0);       // reset state
        check("rom_rd", rom_rd, 0);
        for (int i = 0; i < NUM_LINES; i++) run_line(tab[i]);
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

// File: verification/obj_engine_asserts.sv
/* handshake checks inside the sprite unit, bound to every obj_engine
   a line_start right after a ROM read cancels that write, hence the guard */

`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_engine_asserts (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     line_start,
    input logic                     vb,
    input logic                     rom_rd,
    input logic [`OBJ_SLOTS-1:0]    slot_we,
    input obj_pkg::obj_pix_t        pix
);

    // loader writes one slot at a time
    a_one_write: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(slot_we))
        else $error("several slot_we bits set in one cycle");

    // every read returns exactly one write, one clock later
    a_read_write: assert property (@(posedge clk) disable iff (!arst_n)
        rom_rd && !line_start |=> slot_we != '0)
        else $error("rom_rd not followed by a slot write");

    a_write_read: assert property (@(posedge clk) disable iff (!arst_n)
        slot_we != '0 |-> $past(rom_rd))
        else $error("slot write without a rom_rd the clock before");

    // blanked pixels are transparent
    a_vb_blank: assert property (@(posedge clk) disable iff (!arst_n)
        vb |=> pix.value == 2'b00)
        else $error("opaque pixel after a vb cycle");

endmodule

bind obj_engine obj_engine_asserts u_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .line_start (line_start),
    .vb         (vb),
    .rom_rd     (rom_rd),
    .slot_we    (slot_we),
    .pix        (pix)
);

// File: rtl/obj_engine.sv
/* sprite pixel unit top level
   every clock is one pixel, pix lags h by one clock
   sprite selection for the line comes from outside through attr_we */

`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_engine (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    line_start,
    input  logic                    attr_we,
    input  obj_pkg::obj_attr_t      attr,
    input  logic [7:0]              h,
    input  logic                    vb,
    output logic [`OBJ_ADDR_W-1:0]  rom_addr,
    output logic                    rom_rd,
    input  logic [31:0]             rom_data,
    output obj_pkg::obj_pix_t       pix
);
    import obj_pkg::*;

    logic [`OBJ_SLOTS-1:0]  slot_we;                // one write per slot
    obj_slot_t              slot_data;              // shared load bus
    obj_pix_t               slot_pix [`OBJ_SLOTS];  // slot outputs to mixer

    obj_loader u_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .line_start (line_start),
        .attr_we    (attr_we),
        .attr       (attr),
        .rom_data   (rom_data),
        .rom_addr   (rom_addr),
        .rom_rd     (rom_rd),
        .slot_we    (slot_we),
        .slot_data  (slot_data)
    );

    // slot index doubles as priority, 0 is in front
    genvar g;
    generate
        for (g = 0; g < `OBJ_SLOTS; g++) begin : g_slot
            obj_shifter u_shifter (
                .clk        (clk),
                .arst_n     (arst_n),
                .line_start (line_start),
                .load       (slot_we[g]),
                .load_data  (slot_data),
                .h          (h),
                .pix        (slot_pix[g])
            );
        end
    endgenerate

    obj_mixer u_mixer (
        .clk        (clk),
        .arst_n     (arst_n),
        .vb         (vb),
        .slot_pix   (slot_pix),
        .pix        (pix)
    );

endmodule

// File: rtl/obj_mixer.sv
/* fixed priority mixer, slot 0 on top
   one clock of latency, vb blanks the value and keeps the colour */

`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_mixer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                vb,
    input  obj_pkg::obj_pix_t   slot_pix [`OBJ_SLOTS],
    output obj_pkg::obj_pix_t   pix
);
    import obj_pkg::*;

    obj_pix_t win;  // front-most opaque pixel

    // walk from the back so the lowest opaque slot is written last
    always_comb begin
        win = '0;   // nothing opaque, transparent black
        for (int i = `OBJ_SLOTS - 1; i >= 0; i--) begin
            if (slot_pix[i].value != 2'b00) begin
                win = slot_pix[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix <= '0;
        end else begin
            pix.colour <= win.colour;
            pix.value  <= vb ? 2'b00 : win.value;  // blank during vb
        end
    end

endmodule

// File: rtl/obj_shifter.sv
/* one sprite slot, 16 pixels of 2 bits
   fires once per load when h hits x, pixel is combinational on h
   output is all zero while idle or disarmed */

`timescale 1ns/1ps

module obj_shifter (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                line_start,
    input  logic                load,
    input  obj_pkg::obj_slot_t  load_data,
    input  logic [7:0]          h,
    output obj_pkg::obj_pix_t   pix
);
    import obj_pkg::*;

    obj_slot_t   slot_q;    // x, colour, flip and both planes
    logic        armed;     // loaded and waiting for x
    logic [4:0]  run_cnt;   // pixels left after the current one
    logic        start;
    logic        busy;
    logic        active;    // a pixel is on the output this cycle
    logic [1:0]  lead;

    assign start  = armed && (h == slot_q.x);
    assign busy   = (run_cnt != 5'd0);
    assign active = start || busy;

    // leading bits, mirrored sprites read from the top end
    assign lead = slot_q.hflip ? {slot_q.plane1[15], slot_q.plane0[15]}
                               : {slot_q.plane1[0],  slot_q.plane0[0]};

    always_comb begin
        pix = '0;
        if (active) begin
            pix.colour = slot_q.colour;
            pix.value  = lead;
        end
    end

    // planes load on write and shift one bit per drawn pixel
    always_ff @(posedge clk) begin
        if (load) begin
            slot_q <= load_data;
        end else if (active) begin
            if (slot_q.hflip) begin
                slot_q.plane1 <= {slot_q.plane1[14:0], 1'b0};
                slot_q.plane0 <= {slot_q.plane0[14:0], 1'b0};
            end else begin
                slot_q.plane1 <= {1'b0, slot_q.plane1[15:1]};
                slot_q.plane0 <= {1'b0, slot_q.plane0[15:1]};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            armed   <= 1'b0;
            run_cnt <= 5'd0;
        end else if (line_start) begin
            armed   <= 1'b0;        // slots never carry over a line
            run_cnt <= 5'd0;
        end else if (load) begin
            armed   <= 1'b1;
            run_cnt <= 5'd0;
        end else if (start) begin
            armed   <= 1'b0;        // one pass per load
            run_cnt <= 5'd15;       // first pixel already out
        end else if (busy) begin
            run_cnt <= run_cnt - 5'd1;
        end
    end

endmodule

// File: rtl/obj_loader.sv
/* attribute loader, runs during hblank
   attr_we strobes must be at least 2 clocks apart, ROM has 1 clock latency
   sprites past OBJ_SLOTS in one line get no ROM read and are dropped */

`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_loader (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    line_start,
    input  logic                    attr_we,
    input  obj_pkg::obj_attr_t      attr,
    input  logic [31:0]             rom_data,
    output logic [`OBJ_ADDR_W-1:0]  rom_addr,
    output logic                    rom_rd,
    output logic [`OBJ_SLOTS-1:0]   slot_we,
    output obj_pkg::obj_slot_t      slot_data
);
    import obj_pkg::*;

    // pointer has to reach OBJ_SLOTS itself to mark the bank full
    localparam int PTR_W = $clog2(`OBJ_SLOTS + 1);

    obj_attr_t          attr_q;     // held until its rom row is back
    logic               req_q;      // strobe seen last cycle
    logic               wr_q;       // rom data arrives this cycle
    logic [PTR_W-1:0]   ptr;        // next free slot
    logic [PTR_W-1:0]   wr_slot;    // slot for the pending write
    logic               full;

    assign full = (ptr == PTR_W'(`OBJ_SLOTS));

    // attribute payload
    always_ff @(posedge clk) begin
        if (attr_we) attr_q <= attr;
    end

    // read goes out one clock after the strobe
    assign rom_rd   = req_q && !full;
    assign rom_addr = {attr_q.code, attr_q.row};    // code then row

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q   <= 1'b0;
            wr_q    <= 1'b0;
            ptr     <= '0;
            wr_slot <= '0;
        end else if (line_start) begin
            // new line, start filling from slot 0
            req_q   <= 1'b0;
            wr_q    <= 1'b0;
            ptr     <= '0;
        end else begin
            req_q <= attr_we;
            wr_q  <= rom_rd;
            if (rom_rd) begin
                wr_slot <= ptr;         // claim the slot now
                ptr     <= ptr + 1'b1;  // stops at OBJ_SLOTS via full
            end
        end
    end

    // one-hot write into the claimed slot
    always_comb begin
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            slot_we[i] = wr_q && (wr_slot == PTR_W'(i));
        end
    end

    // attr_q is still stable here, next strobe lands at the earliest now
    always_comb begin
        slot_data.x      = attr_q.x;
        slot_data.colour = attr_q.colour;
        slot_data.hflip  = attr_q.hflip;
        slot_data.plane1 = rom_data[31:16];
        slot_data.plane0 = rom_data[15:0];
    end

endmodule

// File: rtl/obj_pkg.sv
/* sprite unit types
   a pixel value of zero is transparent
   ROM rows are 32 bits, plane 1 in the upper half */

`include "obj_cfg.svh"

package obj_pkg;

    // one sprite entry handed over by the scanner, 25 bits
    typedef struct packed {
        logic [7:0]             x;      // first column drawn
        logic [`OBJ_CODE_W-1:0] code;   // tile number
        logic [`OBJ_ROW_W-1:0]  row;    // line within tile
        logic [2:0]             colour;
        logic                   hflip;  // mirrored output
    } obj_attr_t;

    // what the loader writes into one slot, 44 bits
    typedef struct packed {
        logic [7:0]  x;
        logic [2:0]  colour;
        logic        hflip;
        logic [15:0] plane1;    // msb of pixel value
        logic [15:0] plane0;    // lsb of pixel value
    } obj_slot_t;

    // slot or mixer pixel
    typedef struct packed {
        logic [2:0] colour;
        logic [1:0] value;      // 0 = transparent
    } obj_pix_t;

endpackage

// File: rtl/obj_cfg.svh
/* sprite unit sizing, shared by package and RTL
   OBJ_SLOTS works from 2 to 8
   OBJ_ADDR_W must stay equal to code width plus row width */

`ifndef OBJ_CFG_SVH
`define OBJ_CFG_SVH

// sprites drawn per line
`define OBJ_SLOTS 4

// tile code and row within tile
`define OBJ_CODE_W 9
`define OBJ_ROW_W 4

// rom address = {code, row}
`define OBJ_ADDR_W (`OBJ_CODE_W + `OBJ_ROW_W)

`endif
